// ==== src.f ====
+incdir+.
fetch_pkg.sv
fetch_if.sv
pc_sequencer.sv
icache_fetch.sv
inst_decoder.sv
fetch_top.sv
fetch_asserts.sv
tb_fetch_checker.sv
tb_fetch.sv

// ==== run.sh ====
#!/bin/bash
# build and run the fetch testbench, fail if the log reports a failure
verilator --binary --timing --assert -f src.f --top-module tb_fetch -o sim_fetch \
  > build.log 2>&1 \
  && ./obj_dir/sim_fetch > sim.log 2>&1 \
  || { echo "build or simulation failed, see build.log and sim.log"; exit 1; }
grep -q "=== FAIL ===" sim.log && { echo "test failed, see sim.log"; exit 1; } \
  || { echo "test passed"; exit 0; }

// ==== tb_fetch.sv ====
`timescale 1ns/1ps
`include "fetch_macros.svh"

module tb_fetch;

  localparam int PROG_WORDS = 32;
  localparam int LOOP_END   = 5;  // jal at the end of the loop body
  localparam int FINAL_IDX  = 16; // first word of the final block
  localparam int STEPS      = 5;

  logic                   clk;
  logic                   rst;
  logic                   flush_i;
  logic                   out_ready_i;
  fetch_pkg::addr_t       mem_araddr_o;
  logic                   mem_arvalid_o;
  fetch_pkg::inst_t       mem_rdata_i;
  logic                   mem_rvalid_i;
  logic                   dec_valid_o;
  fetch_pkg::addr_t       dec_pc_o;
  fetch_pkg::inst_t       dec_inst_o;
  fetch_pkg::inst_class_e dec_class_o;
  logic                   end_check;

  // program at the reset pc with one entry per word
  fetch_pkg::inst_t       prog_word  [PROG_WORDS];
  int                     prog_off   [PROG_WORDS]; // jal offset or 0
  fetch_pkg::inst_class_e prog_class [PROG_WORDS];
  fetch_pkg::inst_t       patch_word;              // forward jal written over the loop jal
  int                     patch_off;
  fetch_pkg::inst_t       mem_img    [PROG_WORDS]; // what the bus returns

  // stimulus table with ready percentage, flush flag and delivered count to reach
  int step_pct   [STEPS] = '{100, 60, 0, 50, 30};
  bit step_flush [STEPS] = '{0, 0, 1, 0, 0};
  int step_count [STEPS] = '{6, 10, 10, 23, 29};

  int delivered;
  int mem_delay;
  bit mem_busy;
  bit timed_out;
  int err_cnt;
  int inst_cnt;
  int read_cnt;

  always #2 clk = ~clk;

  fetch_top dut0 (
    .clk           (clk),
    .rst           (rst),
    .flush_i       (flush_i),
    .out_ready_i   (out_ready_i),
    .mem_araddr_o  (mem_araddr_o),
    .mem_arvalid_o (mem_arvalid_o),
    .mem_rdata_i   (mem_rdata_i),
    .mem_rvalid_i  (mem_rvalid_i),
    .dec_valid_o   (dec_valid_o),
    .dec_pc_o      (dec_pc_o),
    .dec_inst_o    (dec_inst_o),
    .dec_class_o   (dec_class_o)
  );

  tb_fetch_checker chk0 (
    .clk           (clk),
    .rst           (rst),
    .flush_i       (flush_i),
    .out_ready_i   (out_ready_i),
    .end_check_i   (end_check),
    .mem_araddr_i  (mem_araddr_o),
    .mem_arvalid_i (mem_arvalid_o),
    .mem_rvalid_i  (mem_rvalid_i),
    .dec_valid_i   (dec_valid_o),
    .dec_pc_i      (dec_pc_o),
    .dec_inst_i    (dec_inst_o),
    .dec_class_i   (dec_class_o),
    .err_cnt_o     (err_cnt),
    .inst_cnt_o    (inst_cnt),
    .read_cnt_o    (read_cnt)
  );

  // J-type jal with rd = x0
  function automatic fetch_pkg::inst_t jal_word(input int off);
    logic [20:0] imm;
    imm = off[20:0];
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd0, 7'b1101111};
  endfunction

  function automatic fetch_pkg::inst_t bus_word(input fetch_pkg::addr_t a);
    fetch_pkg::addr_t off;
    off = a - `FETCH_RESET_PC;
    if (off < 4 * PROG_WORDS)
      return mem_img[off[6:2]];
    return ~a; // fill pattern outside the program
  endfunction

  task automatic set_word(input int i, input fetch_pkg::inst_t w,
                          input fetch_pkg::inst_class_e c, input int off);
    prog_word[i]  = w;
    prog_class[i] = c;
    prog_off[i]   = off;
  endtask

  ////////////////////////////////////////////////////////////
  // memory model answering after 1 to 4 cycles
  ////////////////////////////////////////////////////////////
  always @(negedge clk)
  begin
    if (rst)
    begin
      mem_busy     <= 1'b0;
      mem_rvalid_i <= 1'b0;
    end
    else if (mem_rvalid_i)
    begin
      mem_rvalid_i <= 1'b0;
      mem_busy     <= 1'b0;
    end
    else if (mem_busy)
    begin
      if (mem_delay <= 1)
      begin
        mem_rvalid_i <= 1'b1;
        mem_rdata_i  <= bus_word(mem_araddr_o);
      end
      mem_delay <= mem_delay - 1;
    end
    else if (mem_arvalid_o)
    begin
      mem_busy  <= 1'b1;
      mem_delay <= $urandom_range(1, 4);
    end
  end

  always @(posedge clk)
  begin
    if (rst)
      delivered <= 0;
    else if (dec_valid_o && out_ready_i)
      delivered <= delivered + 1;
  end

  task automatic wait_delivered(input int target, input int pct);
    int t;
    t = 0;
    while (delivered < target && !timed_out)
    begin
      out_ready_i = ($urandom_range(0, 99) < pct);
      @(negedge clk);
      t++;
      if (t > 1000)
      begin
        $display("timeout: only %0d of %0d instructions delivered", delivered, target);
        timed_out = 1'b1;
      end
    end
  endtask

  // stall with the loop jal held in the fetch unit, then patch the code and flush
  task automatic stall_and_flush();
    int t;
    t = 0;
    out_ready_i = 1'b0;
    while (!(dut0.f_if.valid && dut0.f_if.pc == `FETCH_RESET_PC + 4 * LOOP_END) && !timed_out)
    begin
      @(negedge clk);
      t++;
      if (t > 100)
      begin
        $display("timeout: fetch unit never held the loop jal before the flush");
        timed_out = 1'b1;
      end
    end
    if (!timed_out)
    begin
      mem_img[LOOP_END] = patch_word;
      flush_i = 1'b1;
      @(negedge clk);
      flush_i = 1'b0;
    end
  endtask

  task automatic end_run();
    $display("delivered %0d instructions, %0d bus reads, %0d errors", inst_cnt, read_cnt, err_cnt);
    if (timed_out || err_cnt != 0)
      $display("=== FAIL ===");
    else
      $display("=== PASS ===");
    $finish;
  endtask

  ////////////////////////////////////////////////////////////
  // run
  ////////////////////////////////////////////////////////////
  initial
  begin
    clk         = 1'b0;
    rst         = 1'b1;
    flush_i     = 1'b0;
    out_ready_i = 1'b0;
    mem_rdata_i = '0;
    mem_rvalid_i = 1'b0;
    end_check   = 1'b0;
    timed_out   = 1'b0;
    void'($urandom(14));

    for (int i = 0; i < PROG_WORDS; i++)
      set_word(i, ~(`FETCH_RESET_PC + 4 * i), fetch_pkg::OTHER, 0);
    set_word(0, 32'h0010_0093, fetch_pkg::ALU, 0);    // addi x1,x0,1
    set_word(1, 32'h0000_a103, fetch_pkg::LOAD, 0);   // lw x2,0(x1)
    set_word(2, 32'h0020_a423, fetch_pkg::STORE, 0);  // sw x2,8(x1)
    set_word(3, 32'h0020_8463, fetch_pkg::BRANCH, 0); // beq that falls through
    set_word(4, 32'h1234_5037, fetch_pkg::ALU, 0);    // lui
    set_word(LOOP_END, jal_word(-4 * LOOP_END), fetch_pkg::JAL, -4 * LOOP_END);
    set_word(FINAL_IDX, 32'h0030_0193, fetch_pkg::ALU, 0);
    set_word(FINAL_IDX + 1, 32'h0030_a623, fetch_pkg::STORE, 0);
    set_word(FINAL_IDX + 2, 32'h0000_100f, fetch_pkg::OTHER, 0); // fence.i
    set_word(FINAL_IDX + 3, 32'h00c0_a203, fetch_pkg::LOAD, 0);
    set_word(FINAL_IDX + 4, jal_word(0), fetch_pkg::JAL, 0);     // spin
    patch_off  = 4 * (FINAL_IDX - LOOP_END);
    patch_word = jal_word(patch_off);
    for (int i = 0; i < PROG_WORDS; i++)
      mem_img[i] = prog_word[i];

    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    for (int s = 0; s < STEPS; s++)
    begin
      wait_delivered(step_count[s], step_pct[s]);
      if (step_flush[s] && !timed_out)
        stall_and_flush();
      if (timed_out)
        break;
    end

    end_check = 1'b1;
    @(negedge clk);
    @(negedge clk);
    end_run();
  end

endmodule

// ==== tb_fetch_checker.sv ====
`timescale 1ns/1ps
`include "fetch_macros.svh"

module tb_fetch_checker (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   flush_i,
  input  logic                   out_ready_i,
  input  logic                   end_check_i,
  input  fetch_pkg::addr_t       mem_araddr_i,
  input  logic                   mem_arvalid_i,
  input  logic                   mem_rvalid_i,
  input  logic                   dec_valid_i,
  input  fetch_pkg::addr_t       dec_pc_i,
  input  fetch_pkg::inst_t       dec_inst_i,
  input  fetch_pkg::inst_class_e dec_class_i,
  output int                     err_cnt_o,
  output int                     inst_cnt_o,
  output int                     read_cnt_o
);

  localparam int PROG_WORDS = 32;
  localparam int LOOP_END   = 5;

  int                     err_cnt = 0;
  int                     inst_cnt = 0;
  int                     read_cnt = 0;
  int                     epoch_reads [PROG_WORDS];
  int                     loop_visits;
  int                     idx;
  int                     off;
  fetch_pkg::addr_t       exp_pc;
  fetch_pkg::inst_t       exp_inst;
  fetch_pkg::inst_class_e exp_class;
  fetch_pkg::addr_t       held_pc;
  fetch_pkg::inst_t       held_inst;
  bit                     stalled;
  bit                     seen_edge;
  bit                     first_read_done;
  bit                     end_done;

  assign err_cnt_o  = err_cnt;
  assign inst_cnt_o = inst_cnt;
  assign read_cnt_o = read_cnt;

  function automatic int word_idx(input fetch_pkg::addr_t a);
    fetch_pkg::addr_t rel;
    rel = a - `FETCH_RESET_PC;
    if (rel >= 4 * PROG_WORDS || rel[1:0] != 2'b00)
      return -1;
    return int'(rel[6:2]);
  endfunction

  // every loop word read exactly once since the last flush
  task automatic check_epoch();
    for (int i = 0; i <= LOOP_END; i++)
    begin
      if (epoch_reads[i] != 1)
      begin
        $display("loop word %0d was read %0d times since the last flush instead of once",
                 i, epoch_reads[i]);
        err_cnt++;
      end
      epoch_reads[i] = 0;
    end
    for (int i = LOOP_END + 1; i < PROG_WORDS; i++)
      epoch_reads[i] = 0;
  endtask

  always @(posedge clk)
  begin
    if (rst)
    begin
      if (seen_edge && (dec_valid_i || mem_arvalid_i))
      begin
        $display("Mismatch @%0t: dec_valid_o or mem_arvalid_o high during reset", $time);
        err_cnt++;
      end
      seen_edge   = 1'b1;
      exp_pc      = `FETCH_RESET_PC;
      loop_visits = 0;
      stalled     = 1'b0;
      for (int i = 0; i < PROG_WORDS; i++)
        epoch_reads[i] = 0;
    end
    else
    begin
      ////////////////////////////////////////////////////////////
      // output stream
      ////////////////////////////////////////////////////////////
      if (stalled && (!dec_valid_i || dec_pc_i != held_pc || dec_inst_i != held_inst))
      begin
        $display("Mismatch @%0t: output changed while stalled, pc %h inst %h", $time,
                 dec_pc_i, dec_inst_i);
        err_cnt++;
      end
      stalled   = dec_valid_i && !out_ready_i;
      held_pc   = dec_pc_i;
      held_inst = dec_inst_i;

      if (dec_valid_i && out_ready_i)
      begin
        inst_cnt++;
        idx = word_idx(exp_pc);
        if (dec_pc_i != exp_pc)
        begin
          $display("Mismatch @%0t: dec_pc_o %h, expected %h", $time, dec_pc_i, exp_pc);
          err_cnt++;
        end
        if (idx < 0)
        begin
          $display("expected pc %h lies outside the program", exp_pc);
          err_cnt++;
        end
        else
        begin
          exp_inst  = tb_fetch.prog_word[idx];
          exp_class = tb_fetch.prog_class[idx];
          off       = tb_fetch.prog_off[idx];
          if (idx == LOOP_END)
          begin
            loop_visits++;
            if (loop_visits > 2) // loop runs twice, then leaves forward
            begin
              exp_inst = tb_fetch.patch_word;
              off      = tb_fetch.patch_off;
            end
          end
          if (dec_inst_i != exp_inst)
          begin
            $display("Mismatch @%0t: dec_inst_o %h at pc %h, expected %h", $time,
                     dec_inst_i, exp_pc, exp_inst);
            err_cnt++;
          end
          if (dec_class_i != exp_class)
          begin
            $display("Mismatch @%0t: dec_class_o %0d at pc %h, expected %0d", $time,
                     dec_class_i, exp_pc, exp_class);
            err_cnt++;
          end
          exp_pc = exp_pc + ((exp_class == fetch_pkg::JAL) ? fetch_pkg::addr_t'(off) : 32'd4);
        end
      end

      ////////////////////////////////////////////////////////////
      // bus reads
      ////////////////////////////////////////////////////////////
      if (mem_arvalid_i && mem_rvalid_i)
      begin
        read_cnt++;
        if (!first_read_done && mem_araddr_i != `FETCH_RESET_PC)
        begin
          $display("Mismatch @%0t: first read at %h, expected the reset pc", $time, mem_araddr_i);
          err_cnt++;
        end
        first_read_done = 1'b1;
        idx = word_idx(mem_araddr_i);
        if (idx < 0)
        begin
          $display("bus read outside the program at %h", mem_araddr_i);
          err_cnt++;
        end
        else
        begin
          if (epoch_reads[idx] != 0)
          begin
            $display("Mismatch @%0t: repeated bus read of %h since the last flush", $time,
                     mem_araddr_i);
            err_cnt++;
          end
          epoch_reads[idx]++;
        end
      end

      if (flush_i)
        check_epoch();
      if (end_check_i && !end_done)
      begin
        check_epoch();
        end_done = 1'b1;
      end
    end
  end

endmodule

// ==== fetch_asserts.sv ====
`timescale 1ns/1ps

module fetch_asserts (
  input logic             clk,
  input logic             rst,
  input logic             kill_i,
  input logic             flush_i,
  input logic             arvalid,
  input logic             rvalid,
  input fetch_pkg::addr_t araddr,
  input logic             valid,
  input logic             ready
);

  // bus read held until its response
  a_ar_stable : assert property (@(posedge clk) disable iff (rst)
    arvalid && !rvalid |=> arvalid && $stable(araddr))
    else $error("bus read strobe or address changed before rvalid");

  a_valid_held : assert property (@(posedge clk) disable iff (rst)
    valid && !ready |=> valid)
    else $error("fetch valid dropped without a transfer");

  // no new word right after a kill unless one was being held
  a_no_raise_on_kill : assert property (@(posedge clk) disable iff (rst)
    (kill_i || flush_i) && !(valid && !ready) |=> !valid)
    else $error("fetch valid raised in the edge of a kill");

endmodule

bind icache_fetch fetch_asserts asrt0 (
  .clk     (clk),
  .rst     (rst),
  .kill_i  (kill_i),
  .flush_i (flush_i),
  .arvalid (mem_arvalid_o),
  .rvalid  (mem_rvalid_i),
  .araddr  (mem_araddr_o),
  .valid   (out.valid),
  .ready   (out.ready)
);

// ==== fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   flush_i,
  input  logic                   out_ready_i,
  output fetch_pkg::addr_t       mem_araddr_o,
  output logic                   mem_arvalid_o,
  input  fetch_pkg::inst_t       mem_rdata_i,
  input  logic                   mem_rvalid_i,
  output logic                   dec_valid_o,
  output fetch_pkg::addr_t       dec_pc_o,
  output fetch_pkg::inst_t       dec_inst_o,
  output fetch_pkg::inst_class_e dec_class_o
);

  fetch_if f_if ();

  fetch_pkg::addr_t req_pc;
  logic             req_valid;
  logic             req_take;
  logic             redirect;
  fetch_pkg::addr_t redirect_pc;

  ////////////////////////////////////////////////////////////
  // pc -> icache -> decode with the jal redirect looping back
  ////////////////////////////////////////////////////////////
  pc_sequencer pc_seq0 (
    .clk           (clk),
    .rst           (rst),
    .redirect_i    (redirect),
    .redirect_pc_i (redirect_pc),
    .req_take_i    (req_take),
    .req_pc_o      (req_pc),
    .req_valid_o   (req_valid)
  );

  icache_fetch icache0 (
    .clk           (clk),
    .rst           (rst),
    .flush_i       (flush_i),
    .kill_i        (redirect), // wrong path after a jal
    .req_pc_i      (req_pc),
    .req_valid_i   (req_valid),
    .req_take_o    (req_take),
    .mem_araddr_o  (mem_araddr_o),
    .mem_arvalid_o (mem_arvalid_o),
    .mem_rdata_i   (mem_rdata_i),
    .mem_rvalid_i  (mem_rvalid_i),
    .out           (f_if.src)
  );

  inst_decoder dec0 (
    .clk           (clk),
    .rst           (rst),
    .in            (f_if.dst),
    .out_ready_i   (out_ready_i),
    .redirect_o    (redirect),
    .redirect_pc_o (redirect_pc),
    .dec_valid_o   (dec_valid_o),
    .dec_pc_o      (dec_pc_o),
    .dec_inst_o    (dec_inst_o),
    .dec_class_o   (dec_class_o)
  );

endmodule

// ==== inst_decoder.sv ====
`timescale 1ns/1ps

module inst_decoder (
  input  logic                   clk,
  input  logic                   rst,
  fetch_if.dst                   in,
  input  logic                   out_ready_i,
  output logic                   redirect_o,
  output fetch_pkg::addr_t       redirect_pc_o,
  output logic                   dec_valid_o,
  output fetch_pkg::addr_t       dec_pc_o,
  output fetch_pkg::inst_t       dec_inst_o,
  output fetch_pkg::inst_class_e dec_class_o
);

  logic                   accept;
  logic [6:0]             opcode;
  fetch_pkg::inst_class_e cls;
  fetch_pkg::addr_t       j_imm;
  logic                   valid_q;

  ////////////////////////////////////////////////////////////
  // classify
  ////////////////////////////////////////////////////////////
  assign opcode = in.inst[6:0];

  always_comb
  begin
    case (opcode)
      7'b0110011,                          // op
      7'b0010011,                          // op-imm
      7'b0110111,                          // lui
      7'b0010111: cls = fetch_pkg::ALU;    // auipc
      7'b0000011: cls = fetch_pkg::LOAD;
      7'b0100011: cls = fetch_pkg::STORE;
      7'b1100011: cls = fetch_pkg::BRANCH; // fall-through only
      7'b1101111: cls = fetch_pkg::JAL;
      default:    cls = fetch_pkg::OTHER;
    endcase
  end

  // sign-extended J-immediate
  assign j_imm = {{12{in.inst[31]}}, in.inst[19:12], in.inst[20], in.inst[30:21], 1'b0};

  // take a word when empty or draining this cycle
  assign in.ready = !valid_q || out_ready_i;
  assign accept   = in.valid && in.ready;

  assign redirect_o    = accept && (cls == fetch_pkg::JAL);
  assign redirect_pc_o = in.pc + j_imm;

  ////////////////////////////////////////////////////////////
  // output register
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      valid_q <= 1'b0;
    end
    else if (accept)
    begin
      valid_q <= 1'b1;
    end
    else if (out_ready_i)
    begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      dec_pc_o    <= in.pc;
      dec_inst_o  <= in.inst;
      dec_class_o <= cls;
    end
  end

  assign dec_valid_o = valid_q;

endmodule

// ==== icache_fetch.sv ====
`timescale 1ns/1ps
`include "fetch_macros.svh"

module icache_fetch (
  input  logic             clk,
  input  logic             rst,
  input  logic             flush_i,
  input  logic             kill_i,
  input  fetch_pkg::addr_t req_pc_i,
  input  logic             req_valid_i,
  output logic             req_take_o,
  output fetch_pkg::addr_t mem_araddr_o,
  output logic             mem_arvalid_o,
  input  fetch_pkg::inst_t mem_rdata_i,
  input  logic             mem_rvalid_i,
  fetch_if.src             out
);

  ////////////////////////////////////////////////////////////
  // line storage
  ////////////////////////////////////////////////////////////
  fetch_pkg::inst_t        data_mem [`FETCH_LINES];
  fetch_pkg::tag_t         tag_mem  [`FETCH_LINES];
  logic [`FETCH_LINES-1:0] valid_bits;

  fetch_pkg::fetch_state_e state_q;
  fetch_pkg::addr_t        pc_q;   // pc of the request in flight
  fetch_pkg::inst_t        inst_q;
  logic                    wp_q;   // request in flight is wrong-path

  fetch_pkg::idx_t req_idx;
  fetch_pkg::tag_t req_tag;
  fetch_pkg::idx_t fill_idx;
  fetch_pkg::tag_t fill_tag;
  logic            hit;
  logic            drop_now;
  logic            fill_en;

  assign req_idx  = req_pc_i[`FETCH_IDX_W+1:2];
  assign req_tag  = req_pc_i[`FETCH_XLEN-1:`FETCH_IDX_W+2];
  assign fill_idx = pc_q[`FETCH_IDX_W+1:2];
  assign fill_tag = pc_q[`FETCH_XLEN-1:`FETCH_IDX_W+2];

  assign hit      = valid_bits[req_idx] && (tag_mem[req_idx] == req_tag);
  assign drop_now = kill_i | flush_i; // flush acts like fence.i
  assign fill_en  = (state_q == fetch_pkg::MISS_WAIT) && mem_rvalid_i;

  // no new request in the edge that kills the stream
  assign req_take_o = (state_q == fetch_pkg::IDLE) && req_valid_i && !drop_now;

  assign mem_araddr_o  = pc_q; // stable for the whole miss
  assign mem_arvalid_o = (state_q == fetch_pkg::MISS_WAIT);

  assign out.valid = (state_q == fetch_pkg::HOLD);
  assign out.inst  = inst_q;
  assign out.pc    = pc_q;

  ////////////////////////////////////////////////////////////
  // fill path
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk)
  begin
    if (fill_en)
    begin
      data_mem[fill_idx] <= mem_rdata_i;
      tag_mem[fill_idx]  <= fill_tag;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      valid_bits <= '0;
    end
    else if (flush_i)
    begin
      valid_bits <= '0; // clear-all beats a same-edge fill
    end
    else if (fill_en)
    begin
      valid_bits[fill_idx] <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // request FSM
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q <= fetch_pkg::IDLE;
      wp_q    <= 1'b0;
    end
    else
    begin
      case (state_q)
        fetch_pkg::IDLE:
        begin
          if (req_take_o)
          begin
            wp_q    <= 1'b0;
            state_q <= hit ? fetch_pkg::HOLD : fetch_pkg::MISS_WAIT;
          end
        end
        fetch_pkg::MISS_WAIT:
        begin
          if (mem_rvalid_i)
          begin
            // line is filled either way, the word only on the right path
            state_q <= (wp_q || drop_now) ? fetch_pkg::IDLE : fetch_pkg::HOLD;
          end
          else if (drop_now)
          begin
            wp_q <= 1'b1;
          end
        end
        fetch_pkg::HOLD:
        begin
          if (out.ready)
          begin
            state_q <= fetch_pkg::IDLE;
          end
        end
        default:
        begin
          state_q <= fetch_pkg::IDLE;
        end
      endcase
    end
  end

  // word and pc presented to decode
  always_ff @(posedge clk)
  begin
    if (req_take_o)
    begin
      pc_q   <= req_pc_i;
      inst_q <= data_mem[req_idx]; // don't care on a miss
    end
    else if (fill_en)
    begin
      inst_q <= mem_rdata_i;
    end
  end

endmodule

// ==== pc_sequencer.sv ====
`timescale 1ns/1ps
`include "fetch_macros.svh"

module pc_sequencer (
  input  logic             clk,
  input  logic             rst,
  input  logic             redirect_i,
  input  fetch_pkg::addr_t redirect_pc_i,
  input  logic             req_take_i,
  output fetch_pkg::addr_t req_pc_o,
  output logic             req_valid_o
);

  fetch_pkg::addr_t pc_q;

  ////////////////////////////////////////////////////////////
  // next fetch pc
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pc_q <= `FETCH_RESET_PC;
    end
    else if (redirect_i)
    begin
      pc_q <= redirect_pc_i; // jal target wins over a take
    end
    else if (req_take_i)
    begin
      pc_q <= pc_q + 32'd4;
    end
  end

  assign req_pc_o    = pc_q;
  assign req_valid_o = !rst; // always something to fetch once out of reset

endmodule

// ==== fetch_if.sv ====
`timescale 1ns/1ps

// fetched words from the icache to the decoder
interface fetch_if;

  logic             valid;
  fetch_pkg::inst_t inst;
  fetch_pkg::addr_t pc;
  logic             ready;

  // icache side
  modport src (
    output valid,
    output inst,
    output pc,
    input  ready
  );

  // decoder side
  modport dst (
    input  valid,
    input  inst,
    input  pc,
    output ready
  );

endinterface

// ==== fetch_pkg.sv ====
`include "fetch_macros.svh"

package fetch_pkg;

  // widths that carry a meaning
  typedef logic [`FETCH_XLEN-1:0]  addr_t;  // byte address
  typedef logic [`FETCH_XLEN-1:0]  inst_t;  // raw instruction word
  typedef logic [`FETCH_IDX_W-1:0] idx_t;   // cache line index
  typedef logic [`FETCH_TAG_W-1:0] tag_t;   // cache tag

  ////////////////////////////////////////////////////////////
  // fetch unit FSM
  ////////////////////////////////////////////////////////////
  typedef enum logic [1:0] {
    IDLE      = 2'd0, // no request taken, output empty
    MISS_WAIT = 2'd1, // bus read outstanding
    HOLD      = 2'd2  // word presented to decode
  } fetch_state_e;

  ////////////////////////////////////////////////////////////
  // coarse instruction class from the major opcode
  ////////////////////////////////////////////////////////////
  typedef enum logic [2:0] {
    ALU    = 3'd0,
    LOAD   = 3'd1,
    STORE  = 3'd2,
    BRANCH = 3'd3,
    JAL    = 3'd4,
    OTHER  = 3'd5
  } inst_class_e;

endpackage

// ==== fetch_macros.svh ====
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// first fetch address after reset
`define FETCH_RESET_PC 32'h8000_0000

// machine word
`define FETCH_XLEN 32

////////////////////////////////////////////////////////////
// direct-mapped L1 icache geometry with one word per line
////////////////////////////////////////////////////////////
`define FETCH_LINES 256
`define FETCH_IDX_W 8  // addr[9:2]
`define FETCH_TAG_W 22 // addr[31:10]

`endif
